/* hdl/hyper_config.svh */
/*
 * HyperBus controller build parameters
 * Client count, latency and command-address length
 */

`ifndef HYPER_CONFIG_SVH
`define HYPER_CONFIG_SVH

// Peer client ports sharing the bus
`define HYPER_NUM_CLIENTS 2

// Idle cycles between last command-address byte and first data byte
`define HYPER_LATENCY 4

// Command-address phase length in bytes
`define HYPER_CA_BYTES 6

`endif

/* hdl/hyper_pkg.sv */
/*
 * HyperBus controller types
 * Word, address, enable and request types plus the engine states
 */

package hyper_pkg;

    // 16 MB device addressed in 32-bit words
    typedef logic [31:0] word_t;
    typedef logic [21:0] word_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [7:0]  bus_byte_t;

    // One single-word transaction as issued by a client
    typedef struct packed {
        logic       we;
        word_addr_t addr;
        word_t      wdata;
        byte_en_t   be;
    } hyper_req_t;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        LATENCY,
        WDATA,
        RDATA,
        CLOSE
    } xfer_state_t;

endpackage

/* hdl/hyper_client_port.sv */
/*
 * HyperBus client port
 * Holds one request until granted, then waits for finish and pulses done
 */

`timescale 1ns/100ps

module hyper_client_port (
    input  logic                  sys_clk,
    input  logic                  rst_i,
    input  logic                  req_i,
    input  hyper_pkg::hyper_req_t cmd_i,
    input  logic                  grant_i,
    input  logic                  finish_i,
    input  hyper_pkg::word_t      rdata_i,
    output logic                  pending_o,
    output hyper_pkg::hyper_req_t held_o,
    output logic                  busy_o,
    output logic                  done_o,
    output hyper_pkg::word_t      rdata_o
);
    import hyper_pkg::*;

    logic       pending_q;
    logic       inflight_q;
    logic       done_q;
    logic       accept;
    hyper_req_t held_q;
    word_t      rdata_q;

    // Strobes while busy are dropped
    assign accept = req_i && !busy_o;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            pending_q  <= 1'b0;
            inflight_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                pending_q <= 1'b1;
            end else if (grant_i && pending_q) begin
                pending_q  <= 1'b0;
                inflight_q <= 1'b1;
            end
            if (finish_i && inflight_q) begin
                inflight_q <= 1'b0;
                done_q     <= 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            held_q <= cmd_i;
        end
        // Read word stays valid until the next read completes
        if (finish_i && inflight_q && !held_q.we) begin
            rdata_q <= rdata_i;
        end
    end

    assign pending_o = pending_q;
    assign held_o    = held_q;
    assign busy_o    = pending_q | inflight_q;
    assign done_o    = done_q;
    assign rdata_o   = rdata_q;

    a_done_pulse: assert property (
        @(posedge sys_clk) disable iff (rst_i) done_o |=> !done_o
    );

endmodule

/* hdl/hyper_arbiter.sv */
/*
 * HyperBus round-robin arbiter
 * Picks the next pending client, starts the engine and returns finish to the owner
 */

`timescale 1ns/100ps

`include "hyper_config.svh"

module hyper_arbiter (
    input  logic                                           sys_clk,
    input  logic                                           rst_i,
    input  logic [`HYPER_NUM_CLIENTS-1:0]                  pending_i,
    input  hyper_pkg::hyper_req_t [`HYPER_NUM_CLIENTS-1:0] held_i,
    input  logic                                           eng_idle_i,
    input  logic                                           eng_finish_i,
    output logic [`HYPER_NUM_CLIENTS-1:0]                  grant_o,
    output logic [`HYPER_NUM_CLIENTS-1:0]                  finish_o,
    output logic                                           start_o,
    output hyper_pkg::hyper_req_t                          req_o
);
    localparam int N     = `HYPER_NUM_CLIENTS;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic             active_q;
    logic             start_q;
    logic [IDX_W-1:0] owner_q;
    logic [N-1:0]     grant_q;
    logic [N-1:0]     finish_q;
    logic             pick_valid;
    logic [IDX_W-1:0] pick_idx;
    logic             can_start;

    // Search starts one past the last owner
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = owner_q;
        for (int i = 1; i <= N; i++) begin
            cand = int'(owner_q) + i;
            if (cand >= N) begin
                cand = cand - N;
            end
            if (!pick_valid && pending_i[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    assign can_start = pick_valid && eng_idle_i && !active_q;

    // owner_q doubles as the last-owner pointer; reset value makes client 0 first
    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            active_q <= 1'b0;
            start_q  <= 1'b0;
            owner_q  <= IDX_W'(N - 1);
            grant_q  <= '0;
            finish_q <= '0;
        end else begin
            start_q  <= can_start;
            grant_q  <= '0;
            finish_q <= '0;
            if (can_start) begin
                active_q          <= 1'b1;
                owner_q           <= pick_idx;
                grant_q[pick_idx] <= 1'b1;
            end
            if (eng_finish_i) begin
                active_q          <= 1'b0;
                finish_q[owner_q] <= 1'b1;
            end
        end
    end

    assign grant_o  = grant_q;
    assign finish_o = finish_q;
    assign start_o  = start_q;
    assign req_o    = held_i[owner_q];

    a_grant_onehot: assert property (
        @(posedge sys_clk) disable iff (rst_i)
        (grant_o != '0) |-> ($onehot(grant_o) && ((grant_o & pending_i) == grant_o))
    );

endmodule

/* hdl/hyper_xfer_engine.sv */
/*
 * HyperBus transaction engine
 * Serialises one word request into command-address, latency and data phases
 */

`timescale 1ns/100ps

`include "hyper_config.svh"

module hyper_xfer_engine (
    input  logic                  sys_clk,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  hyper_pkg::hyper_req_t req_i,
    output logic                  idle_o,
    output logic                  finish_o,
    output hyper_pkg::word_t      rdata_o,
    output logic                  hyper_cs_n_o,
    output hyper_pkg::bus_byte_t  hyper_dq_o,
    output logic                  hyper_dq_oe_o,
    output logic                  hyper_rwds_o,
    output logic                  hyper_rwds_oe_o,
    input  hyper_pkg::bus_byte_t  hyper_dq_i,
    input  logic                  hyper_rwds_i
);
    import hyper_pkg::*;

    localparam int BYTE_W     = $bits(bus_byte_t);
    localparam int WORD_BYTES = $bits(word_t) / BYTE_W;
    localparam int CA_W       = BYTE_W * `HYPER_CA_BYTES;
    localparam int CNT_MAX    = (`HYPER_CA_BYTES > `HYPER_LATENCY) ?
                                `HYPER_CA_BYTES : `HYPER_LATENCY;
    localparam int CNT_W      = $clog2(CNT_MAX) + 1;

    xfer_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CA_W-1:0]  ca_q;
    logic             we_q;
    word_t            wdata_q;
    byte_en_t         be_q;
    word_t            rdata_q;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CMD;
                        cnt_q   <= '0;
                    end
                end
                CMD: begin
                    if (cnt_q == CNT_W'(`HYPER_CA_BYTES - 1)) begin
                        state_q <= LATENCY;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                LATENCY: begin
                    if (cnt_q == CNT_W'(`HYPER_LATENCY - 1)) begin
                        state_q <= we_q ? WDATA : RDATA;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                WDATA: begin
                    if (cnt_q == CNT_W'(WORD_BYTES - 1)) begin
                        state_q <= CLOSE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                // Memory marks each valid byte with rwds
                RDATA: begin
                    if (hyper_rwds_i) begin
                        if (cnt_q == CNT_W'(WORD_BYTES - 1)) begin
                            state_q <= CLOSE;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                CLOSE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    // Read flag on top, word address at the bottom
                    ca_q    <= {~req_i.we, {(CA_W - 1 - $bits(word_addr_t)){1'b0}}, req_i.addr};
                    we_q    <= req_i.we;
                    wdata_q <= req_i.wdata;
                    be_q    <= req_i.be;
                end
            end
            CMD: begin
                ca_q <= ca_q << BYTE_W;
            end
            WDATA: begin
                wdata_q <= wdata_q >> BYTE_W;
                be_q    <= be_q >> 1;
            end
            RDATA: begin
                if (hyper_rwds_i) begin
                    rdata_q <= {hyper_dq_i, rdata_q[$bits(word_t)-1:BYTE_W]};
                end
            end
            default: begin
            end
        endcase
    end

    assign idle_o   = (state_q == IDLE);
    assign finish_o = (state_q == CLOSE);
    assign rdata_o  = rdata_q;

    assign hyper_cs_n_o    = (state_q == IDLE) || (state_q == CLOSE);
    assign hyper_dq_o      = (state_q == WDATA) ? wdata_q[BYTE_W-1:0] : ca_q[CA_W-1 -: BYTE_W];
    assign hyper_dq_oe_o   = (state_q == CMD) || (state_q == WDATA);
    // High rwds masks the byte on writes
    assign hyper_rwds_o    = ~be_q[0];
    assign hyper_rwds_oe_o = (state_q == WDATA);

    a_idle_bus: assert property (
        @(posedge sys_clk) disable iff (rst_i)
        (state_q == IDLE) |-> (hyper_cs_n_o && !hyper_dq_oe_o && !hyper_rwds_oe_o)
    );

endmodule

/* hdl/hyper_ctrl_top.sv */
/*
 * HyperBus controller top level
 * Client ports share one transaction engine through a round-robin arbiter
 */

`timescale 1ns/100ps

`include "hyper_config.svh"

module hyper_ctrl_top (
    input  logic                                           sys_clk,
    input  logic                                           rst_i,
    input  logic [`HYPER_NUM_CLIENTS-1:0]                  cl_req_i,
    input  hyper_pkg::hyper_req_t [`HYPER_NUM_CLIENTS-1:0] cl_cmd_i,
    output logic [`HYPER_NUM_CLIENTS-1:0]                  cl_busy_o,
    output logic [`HYPER_NUM_CLIENTS-1:0]                  cl_done_o,
    output hyper_pkg::word_t [`HYPER_NUM_CLIENTS-1:0]      cl_rdata_o,
    output logic                                           hyper_cs_n_o,
    output hyper_pkg::bus_byte_t                           hyper_dq_o,
    output logic                                           hyper_dq_oe_o,
    output logic                                           hyper_rwds_o,
    output logic                                           hyper_rwds_oe_o,
    input  hyper_pkg::bus_byte_t                           hyper_dq_i,
    input  logic                                           hyper_rwds_i
);
    import hyper_pkg::*;

    logic [`HYPER_NUM_CLIENTS-1:0]       pending;
    hyper_req_t [`HYPER_NUM_CLIENTS-1:0] held;
    logic [`HYPER_NUM_CLIENTS-1:0]       grant;
    logic [`HYPER_NUM_CLIENTS-1:0]       finish;
    logic                                eng_start;
    hyper_req_t                          eng_req;
    logic                                eng_idle;
    logic                                eng_finish;
    word_t                               eng_rdata;

    for (genvar i = 0; i < `HYPER_NUM_CLIENTS; i++) begin : g_port
        hyper_client_port u_port (
            .sys_clk   (sys_clk),
            .rst_i     (rst_i),
            .req_i     (cl_req_i[i]),
            .cmd_i     (cl_cmd_i[i]),
            .grant_i   (grant[i]),
            .finish_i  (finish[i]),
            .rdata_i   (eng_rdata),
            .pending_o (pending[i]),
            .held_o    (held[i]),
            .busy_o    (cl_busy_o[i]),
            .done_o    (cl_done_o[i]),
            .rdata_o   (cl_rdata_o[i])
        );
    end

    hyper_arbiter u_arbiter (
        .sys_clk      (sys_clk),
        .rst_i        (rst_i),
        .pending_i    (pending),
        .held_i       (held),
        .eng_idle_i   (eng_idle),
        .eng_finish_i (eng_finish),
        .grant_o      (grant),
        .finish_o     (finish),
        .start_o      (eng_start),
        .req_o        (eng_req)
    );

    hyper_xfer_engine u_engine (
        .sys_clk         (sys_clk),
        .rst_i           (rst_i),
        .start_i         (eng_start),
        .req_i           (eng_req),
        .idle_o          (eng_idle),
        .finish_o        (eng_finish),
        .rdata_o         (eng_rdata),
        .hyper_cs_n_o    (hyper_cs_n_o),
        .hyper_dq_o      (hyper_dq_o),
        .hyper_dq_oe_o   (hyper_dq_oe_o),
        .hyper_rwds_o    (hyper_rwds_o),
        .hyper_rwds_oe_o (hyper_rwds_oe_o),
        .hyper_dq_i      (hyper_dq_i),
        .hyper_rwds_i    (hyper_rwds_i)
    );

endmodule

/* bench/hyper_ram_model.sv */
/*
 * Behavioural HyperBus memory
 * Decodes command-address bytes, merges masked writes, answers reads with rwds
 */

`timescale 1ns/100ps

`include "hyper_config.svh"

module hyper_ram_model #(
    parameter int EXTRA_WAIT = 2
) (
    input  logic                  sys_clk,
    input  logic                  cs_n_i,
    input  hyper_pkg::bus_byte_t  dq_i,
    input  logic                  dq_oe_i,
    input  logic                  rwds_i,
    input  logic                  rwds_oe_i,
    output hyper_pkg::bus_byte_t  dq_o,
    output logic                  rwds_o,
    output int                    xfer_cnt_o,
    output logic                  last_we_o,
    output hyper_pkg::word_addr_t last_addr_o,
    output int                    last_len_o,
    output int                    fault_cnt_o
);
    import hyper_pkg::*;

    localparam int CA_N    = `HYPER_CA_BYTES;
    localparam int DATA_AT = `HYPER_CA_BYTES + `HYPER_LATENCY;
    // Read bytes are presented one cycle ahead of the sampling edge
    localparam int READ_AT = DATA_AT - 1 + EXTRA_WAIT;

    word_t                 mem [word_addr_t];
    logic [8*CA_N-1:0]     ca = '0;
    logic                  ca_read;
    word_addr_t            ca_addr;
    int                    cnt = 0;
    logic                  in_xfer = 1'b0;
    logic                  drive = 1'b0;
    bus_byte_t             dq_q = '0;
    int                    xfer_cnt = 0;
    logic                  last_we = 1'b0;
    word_addr_t            last_addr = '0;
    int                    last_len = 0;
    int                    fault_cnt = 0;

    assign ca_read = ca[8*CA_N-1];
    assign ca_addr = ca[$bits(word_addr_t)-1:0];

    function automatic word_t fetch(word_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return '1;
    endfunction

    task automatic report_fault(string what);
        $display("bus fault at %0t: %s", $time, what);
        fault_cnt++;
    endtask

    always @(posedge sys_clk) begin
        int    idx;
        word_t w;
        if (cs_n_i !== 1'b0) begin
            if (in_xfer) begin
                xfer_cnt  <= xfer_cnt + 1;
                last_we   <= !ca_read;
                last_addr <= ca_addr;
                last_len  <= cnt;
            end
            in_xfer <= 1'b0;
            cnt     <= 0;
            drive   <= 1'b0;
        end else begin
            in_xfer <= 1'b1;
            cnt     <= cnt + 1;
            if (dq_oe_i && drive) begin
                report_fault("dq driven by controller and memory at once");
            end
            if (cnt < CA_N) begin
                if (!dq_oe_i) begin
                    report_fault("command-address byte not driven by the controller");
                end
                ca <= {ca[8*CA_N-9:0], dq_i};
            end else if (ca_read) begin
                if (rwds_oe_i) begin
                    report_fault("controller drives rwds during a read");
                end
                idx = cnt - READ_AT;
                drive <= (idx >= 0) && (idx < 4);
                if ((idx >= 0) && (idx < 4)) begin
                    w = fetch(ca_addr);
                    dq_q <= w[8*idx +: 8];
                end
            end else if (cnt >= DATA_AT) begin
                idx = cnt - DATA_AT;
                if (idx >= 4) begin
                    report_fault("write keeps chip select low past four data bytes");
                end else if (!dq_oe_i || !rwds_oe_i) begin
                    report_fault("write data byte sent without dq and rwds driven");
                end else if (!rwds_i) begin
                    w = fetch(ca_addr);
                    w[8*idx +: 8] = dq_i;
                    mem[ca_addr] = w;
                end
            end
        end
    end

    assign dq_o        = dq_q;
    assign rwds_o      = drive;
    assign xfer_cnt_o  = xfer_cnt;
    assign last_we_o   = last_we;
    assign last_addr_o = last_addr;
    assign last_len_o  = last_len;
    assign fault_cnt_o = fault_cnt;

endmodule

/* bench/hyper_tb.sv */
/*
 * HyperBus controller testbench
 * Directed and random client traffic checked against a reference word memory
 */

`timescale 1ns/100ps

`include "hyper_config.svh"

module hyper_tb;
    import hyper_pkg::*;

    localparam int N               = `HYPER_NUM_CLIENTS;
    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DLY       = 10;
    localparam int NUM_RANDOM      = 200;
    localparam int RAND_PER_CLIENT = NUM_RANDOM / 2;
    localparam int NUM_OPS         = 12 + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES  = 40 * NUM_OPS + 100;
    localparam int WRITE_LEN       = `HYPER_CA_BYTES + `HYPER_LATENCY + 4;
    localparam int WINDOW          = 64;

    logic                sys_clk = 1'b0;
    logic                rst_i;
    logic [N-1:0]        cl_req;
    hyper_req_t [N-1:0]  cl_cmd;
    logic [N-1:0]        cl_busy;
    logic [N-1:0]        cl_done;
    word_t [N-1:0]       cl_rdata;
    logic                cs_n;
    bus_byte_t           dq_ctl;
    logic                dq_oe;
    logic                rwds_ctl;
    logic                rwds_oe;
    bus_byte_t           dq_mem;
    logic                rwds_mem;
    int                  ram_xfers;
    logic                ram_last_we;
    word_addr_t          ram_last_addr;
    int                  ram_last_len;
    int                  ram_faults;

    logic [31:0]         lcg_state = 32'h023d_7890;
    word_t               ref_mem [word_addr_t];
    hyper_req_t          rand_ops [2][RAND_PER_CLIENT];
    int                  mismatch_cnt = 0;
    int                  ops_issued = 0;
    int                  cycle_cnt = 0;
    int                  last_owner = N - 1;
    int                  done_total [N];

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    hyper_ctrl_top DUT (
        .sys_clk         (sys_clk),
        .rst_i           (rst_i),
        .cl_req_i        (cl_req),
        .cl_cmd_i        (cl_cmd),
        .cl_busy_o       (cl_busy),
        .cl_done_o       (cl_done),
        .cl_rdata_o      (cl_rdata),
        .hyper_cs_n_o    (cs_n),
        .hyper_dq_o      (dq_ctl),
        .hyper_dq_oe_o   (dq_oe),
        .hyper_rwds_o    (rwds_ctl),
        .hyper_rwds_oe_o (rwds_oe),
        .hyper_dq_i      (dq_mem),
        .hyper_rwds_i    (rwds_mem)
    );

    hyper_ram_model u_ram (
        .sys_clk     (sys_clk),
        .cs_n_i      (cs_n),
        .dq_i        (dq_ctl),
        .dq_oe_i     (dq_oe),
        .rwds_i      (rwds_ctl),
        .rwds_oe_i   (rwds_oe),
        .dq_o        (dq_mem),
        .rwds_o      (rwds_mem),
        .xfer_cnt_o  (ram_xfers),
        .last_we_o   (ram_last_we),
        .last_addr_o (ram_last_addr),
        .last_len_o  (ram_last_len),
        .fault_cnt_o (ram_faults)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic hyper_req_t make_req(logic we, word_addr_t addr, word_t wdata,
                                            byte_en_t be);
        hyper_req_t r;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        r.be    = be;
        return r;
    endfunction

    // Unwritten words read as all ones
    function automatic word_t ref_read(word_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return '1;
    endfunction

    function automatic void ref_write(word_addr_t a, word_t d, byte_en_t be);
        word_t w;
        w = ref_read(a);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        ref_mem[a] = w;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d mismatches, %0d bus faults, %0d operations issued",
                 mismatch_cnt, ram_faults, ops_issued);
    endtask

    // One strobe, then wait for done and check what the memory saw
    task automatic issue_op(input int c, input hyper_req_t cmd, output int done_cycle);
        word_t exp;
        exp = ref_read(cmd.addr);
        if (cmd.we) begin
            ref_write(cmd.addr, cmd.wdata, cmd.be);
        end
        ops_issued++;
        @(posedge sys_clk);
        #DRIVE_DLY;
        cl_cmd[c] = cmd;
        cl_req[c] = 1'b1;
        @(posedge sys_clk);
        #DRIVE_DLY;
        cl_req[c] = 1'b0;
        check_value($sformatf("cl_busy_o[%0d]", c), cl_busy[c], 1'b1);
        while (!cl_done[c]) begin
            @(posedge sys_clk);
            #DRIVE_DLY;
        end
        done_cycle = cycle_cnt;
        last_owner = c;
        check_value($sformatf("cl_busy_o[%0d] at done", c), cl_busy[c], 1'b0);
        check_value("ram_last_addr", ram_last_addr, cmd.addr);
        check_value("ram_last_we", ram_last_we, cmd.we);
        if (cmd.we) begin
            check_value("write cs_n low cycles", ram_last_len, WRITE_LEN);
        end else begin
            check_value($sformatf("cl_rdata_o[%0d]", c), cl_rdata[c], exp);
        end
    endtask

    task automatic run_pair(input hyper_req_t cmd0, input hyper_req_t cmd1);
        int t0;
        int t1;
        int first;
        first = (last_owner + 1) % N;
        fork
            issue_op(0, cmd0, t0);
            issue_op(1, cmd1, t1);
        join
        check_value("first served client", (t0 < t1) ? 0 : 1, first);
    endtask

    task automatic ignored_strobe_test();
        int         t;
        int         dones_before;
        int         xfers_before;
        hyper_req_t stray;
        stray        = make_req(1'b1, 22'h000_030, 32'h5a5a_5a5a, 4'hf);
        dones_before = done_total[0];
        xfers_before = ram_xfers;
        fork
            issue_op(0, make_req(1'b1, 22'h000_020, 32'hcafe_f00d, 4'hf), t);
            begin
                repeat (3) @(posedge sys_clk);
                #DRIVE_DLY;
                cl_cmd[0] = stray;
                cl_req[0] = 1'b1;
                @(posedge sys_clk);
                #DRIVE_DLY;
                cl_req[0] = 1'b0;
            end
        join
        // Room for a wrongly accepted request to show up
        repeat (2 * WRITE_LEN + 10) @(posedge sys_clk);
        #DRIVE_DLY;
        check_value("client 0 done count", done_total[0] - dones_before, 1);
        check_value("bus transaction count", ram_xfers - xfers_before, 1);
        issue_op(0, make_req(1'b0, stray.addr, '0, '0), t);
    endtask

    task automatic random_client(input int c);
        int t;
        for (int k = 0; k < RAND_PER_CLIENT; k++) begin
            issue_op(c, rand_ops[c][k], t);
        end
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt++;
        for (int c = 0; c < N; c++) begin
            if (cl_done[c] === 1'b1) begin
                done_total[c]++;
            end
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_summary();
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        int          t;
        rst_i  = 1'b1;
        cl_req = '0;
        cl_cmd = '0;
        for (int c = 0; c < N; c++) begin
            done_total[c] = 0;
        end
        repeat (3) @(posedge sys_clk);
        #DRIVE_DLY;
        rst_i = 1'b0;

        check_value("hyper_cs_n_o", cs_n, 1'b1);
        check_value("hyper_dq_oe_o", dq_oe, 1'b0);
        check_value("hyper_rwds_oe_o", rwds_oe, 1'b0);
        check_value("cl_busy_o", cl_busy, '0);
        check_value("cl_done_o", cl_done, '0);

        // Simultaneous writes right after reset go to client 0 first
        run_pair(make_req(1'b1, 22'h000_008, 32'h0123_4567, 4'hf),
                 make_req(1'b1, 22'h000_048, 32'h89ab_cdef, 4'hf));

        issue_op(0, make_req(1'b1, 22'h000_004, 32'hdead_beef, 4'hf), t);
        issue_op(0, make_req(1'b0, 22'h000_004, '0, '0), t);

        run_pair(make_req(1'b0, 22'h000_008, '0, '0),
                 make_req(1'b0, 22'h000_048, '0, '0));

        // Partial enables merge into a fresh word
        issue_op(1, make_req(1'b1, 22'h000_050, 32'h1122_3344, 4'b0101), t);
        issue_op(1, make_req(1'b0, 22'h000_050, '0, '0), t);
        issue_op(1, make_req(1'b1, 22'h000_050, 32'haabb_ccdd, 4'b1000), t);
        issue_op(1, make_req(1'b0, 22'h000_050, '0, '0), t);

        ignored_strobe_test();

        for (int k = 0; k < RAND_PER_CLIENT; k++) begin
            for (int c = 0; c < 2; c++) begin
                r = next_rand();
                rand_ops[c][k] = make_req(r[31],
                                          word_addr_t'(c * WINDOW) + word_addr_t'(r[30:25]),
                                          next_rand(), r[24:21]);
            end
        end
        fork
            random_client(0);
            random_client(1);
        join

        check_value("total bus transactions", ram_xfers, ops_issued);
        print_summary();
        if (mismatch_cnt == 0 && ram_faults == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/hyper_pkg.sv
hdl/hyper_client_port.sv
hdl/hyper_arbiter.sv
hdl/hyper_xfer_engine.sv
hdl/hyper_ctrl_top.sv
bench/hyper_ram_model.sv
bench/hyper_tb.sv

/* Makefile */
# Verilator build and run for the HyperBus controller testbench

VERILATOR ?= verilator
TOP       ?= hyper_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
